// ==== frv_front.f ====
hw/frv_front_pkg.sv
hw/frv_fetch.sv
hw/frv_decode.sv
hw/frv_pipe_reg.sv
hw/frv_front.sv
test/tb_frv_front.sv

// ==== hw/frv_decode.sv ====
`timescale 1ns/1ns
// Combinational RV32I decoder
// Turns one fetched word into the wide decoded record.
// Fetch faults and unsupported encodings come out as traps.

module frv_decode (
    input  frv_front_pkg::frv_fetch_t i_fetch, // Word, pc and fault
    output frv_front_pkg::frv_dec_t   o_dec    // Decoded record
);

    import frv_front_pkg::*;

    // Supported base opcodes
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } frv_opc_e;

    logic [31:0] instr;
    frv_opc_e    opc;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] shamt;
    logic        alt_ok;   // funct7 is zero or the SUB/SRA pattern

    assign instr  = i_fetch.instr;
    assign opc    = frv_opc_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign alt_ok = (funct7 & 7'b1011111) == 7'd0;

    // Immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'd0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign shamt = {27'd0, instr[24:20]};

    always_comb begin
        frv_uop_e    uop;
        frv_fu_e     fu;
        logic [31:0] imm;
        logic        bad;
        logic        use_rd;
        logic        use_rs1;
        logic        use_rs2;
        logic        trap;

        uop     = UOP_NONE;
        fu      = FU_ALU;
        imm     = 32'd0;
        bad     = 1'b0;
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b0;

        case (opc)
            OPC_LUI: begin
                uop     = UOP_LUI;
                imm     = imm_u;
                use_rs1 = 1'b0;
            end
            OPC_AUIPC: begin
                uop     = UOP_AUIPC;
                imm     = imm_u;
                use_rs1 = 1'b0;
            end
            OPC_JAL: begin
                uop     = UOP_JAL;
                fu      = FU_JMP;
                imm     = imm_j;
                use_rs1 = 1'b0;
            end
            OPC_JALR: begin
                uop = UOP_JALR;
                fu  = FU_JMP;
                imm = imm_i;
                bad = funct3 != 3'b000;
            end
            OPC_BRANCH: begin
                fu      = FU_JMP;
                imm     = imm_b;
                use_rd  = 1'b0;   // Branches write nothing
                use_rs2 = 1'b1;
                case (funct3)
                    3'b000:  uop = UOP_BEQ;
                    3'b001:  uop = UOP_BNE;
                    3'b100:  uop = UOP_BLT;
                    3'b101:  uop = UOP_BGE;
                    3'b110:  uop = UOP_BLTU;
                    3'b111:  uop = UOP_BGEU;
                    default: bad = 1'b1;
                endcase
            end
            OPC_LOAD: begin
                fu  = FU_MEM;
                imm = imm_i;
                case (funct3)
                    3'b000:  uop = UOP_LB;
                    3'b001:  uop = UOP_LH;
                    3'b010:  uop = UOP_LW;
                    3'b100:  uop = UOP_LBU;
                    3'b101:  uop = UOP_LHU;
                    default: bad = 1'b1;
                endcase
            end
            OPC_STORE: begin
                fu      = FU_MEM;
                imm     = imm_s;
                use_rd  = 1'b0;
                use_rs2 = 1'b1;
                case (funct3)
                    3'b000:  uop = UOP_SB;
                    3'b001:  uop = UOP_SH;
                    3'b010:  uop = UOP_SW;
                    default: bad = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                imm = imm_i;
                case (funct3)
                    3'b000: uop = UOP_ADD;
                    3'b010: uop = UOP_SLT;
                    3'b011: uop = UOP_SLTU;
                    3'b100: uop = UOP_XOR;
                    3'b110: uop = UOP_OR;
                    3'b111: uop = UOP_AND;
                    3'b001: begin
                        uop = UOP_SLL;
                        imm = shamt;         // Shift amount only
                        bad = funct7 != 7'd0;
                    end
                    default: begin           // SRLI / SRAI
                        uop = funct7[5] ? UOP_SRA : UOP_SRL;
                        imm = shamt;
                        bad = !alt_ok;
                    end
                endcase
            end
            OPC_OP: begin
                use_rs2 = 1'b1;
                // Only ADD/SUB and SRL/SRA take bit 30 of funct7
                bad = (funct3 == 3'b000 || funct3 == 3'b101) ? !alt_ok : funct7 != 7'd0;
                case (funct3)
                    3'b000:  uop = funct7[5] ? UOP_SUB : UOP_ADD;
                    3'b001:  uop = UOP_SLL;
                    3'b010:  uop = UOP_SLT;
                    3'b011:  uop = UOP_SLTU;
                    3'b100:  uop = UOP_XOR;
                    3'b101:  uop = funct7[5] ? UOP_SRA : UOP_SRL;
                    3'b110:  uop = UOP_OR;
                    default: uop = UOP_AND;
                endcase
            end
            default: bad = 1'b1;   // CSR, FENCE, system and the rest
        endcase

        trap = i_fetch.error | bad;
        if (trap) begin            // Trap record carries no operands
            uop     = UOP_NONE;
            fu      = FU_ALU;
            imm     = 32'd0;
            use_rd  = 1'b0;
            use_rs1 = 1'b0;
            use_rs2 = 1'b0;
        end

        o_dec.rd    = use_rd  ? instr[11:7]  : 5'd0;
        o_dec.rs1   = use_rs1 ? instr[19:15] : 5'd0;
        o_dec.rs2   = use_rs2 ? instr[24:20] : 5'd0;
        o_dec.imm   = imm;
        o_dec.pc    = i_fetch.pc;
        o_dec.uop   = uop;
        o_dec.fu    = fu;
        o_dec.trap  = trap;
        o_dec.instr = instr;
    end

endmodule

// ==== hw/frv_fetch.sv ====
`timescale 1ns/1ns
// Fetch stage of the RV32I front end
// Keeps the PC, issues one word read at a time to the instruction memory
// and buffers one response while the stage register is busy.
// A redirect or flush drops the in-flight and buffered words.

module frv_fetch #(
    parameter logic [31:0] PC_RESET_VALUE = 32'h8000_0000
) (
    input  logic                      g_clk,        // Core clock
    input  logic                      i_rst_n,      // Async reset, active low
    input  logic                      i_cf_req,     // Control flow change request
    input  logic [31:0]               i_cf_target,  // New fetch address
    output logic                      o_cf_ack,     // Acked in the same cycle
    input  logic                      i_flush,      // Drop in-flight words
    input  logic                      i_stall,      // Stage register busy
    output logic                      o_imem_cen,   // Read request
    output logic [31:0]               o_imem_addr,  // Word address
    input  logic                      i_imem_stall, // Memory not ready
    input  logic [31:0]               i_imem_rdata, // Response word
    input  logic                      i_imem_error, // Response fault
    output logic                      o_valid,      // Fetched item valid
    output frv_front_pkg::frv_fetch_t o_fetch       // Fetched item
);

    import frv_front_pkg::*;

    logic        run_q;       // Low until first cycle after reset
    logic [31:0] pc_q;        // Address of next request
    logic [31:0] req_pc_q;    // Address of outstanding request
    logic        req_q;       // One request outstanding
    logic        drop_q;      // Outstanding response is stale
    logic        buf_valid_q; // Buffer holds a word
    frv_fetch_t  buf_q;
    frv_fetch_t  resp;        // Response as it arrives

    logic kill;               // Redirect or flush this cycle
    logic resp_valid;         // Live response on the bus
    logic hold;               // Word presented but stage busy
    logic accept;             // Request taken by memory

    // --------------------------------------------------
    // Request side
    assign kill        = i_cf_req | i_flush;
    assign o_cf_ack    = run_q & i_cf_req;
    assign resp_valid  = req_q & ~i_imem_stall & ~drop_q;
    assign hold        = (buf_valid_q | resp_valid) & i_stall;
    assign o_imem_cen  = run_q & ~kill & ~hold;   // Only when buffer frees up
    assign o_imem_addr = pc_q;
    assign accept      = o_imem_cen & ~i_imem_stall;

    // --------------------------------------------------
    // Response side
    assign resp.pc    = req_pc_q;
    assign resp.instr = i_imem_rdata;
    assign resp.error = i_imem_error;

    assign o_valid = (buf_valid_q | resp_valid) & ~kill;
    assign o_fetch = buf_valid_q ? buf_q : resp;  // Buffer is older

    always_ff @(posedge g_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run_q       <= 1'b0;
            pc_q        <= PC_RESET_VALUE;
            req_q       <= 1'b0;
            drop_q      <= 1'b0;
            buf_valid_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (i_cf_req) begin
                pc_q <= {i_cf_target[31:2], 2'b00};  // Word aligned target
            end else if (accept) begin
                pc_q <= pc_q + 32'd4;
            end
            if (accept) begin
                req_q <= 1'b1;
            end else if (!i_imem_stall) begin
                req_q <= 1'b0;                        // Response returned
            end
            if (i_imem_stall) begin
                drop_q <= drop_q | (kill & req_q);    // Kill while still pending
            end else begin
                drop_q <= 1'b0;
            end
            if (kill) begin
                buf_valid_q <= 1'b0;
            end else if (resp_valid && i_stall) begin
                buf_valid_q <= 1'b1;                  // Park the response
            end else if (!i_stall) begin
                buf_valid_q <= 1'b0;                  // Consumed downstream
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            req_pc_q <= pc_q;
        end
        if (resp_valid && i_stall) begin
            buf_q <= resp;
        end
    end

    // --------------------------------------------------
    // Memory port checks
    a_addr_aligned: assert property (
        @(posedge g_clk) disable iff (!i_rst_n)
        o_imem_cen |-> (o_imem_addr[1:0] == 2'b00)
    ) else $error("fetch address not word aligned");

    a_addr_held: assert property (
        @(posedge g_clk) disable iff (!i_rst_n)
        (o_imem_cen && i_imem_stall) |=> $stable(o_imem_addr)
    ) else $error("fetch address changed during memory stall");

endmodule

// ==== hw/frv_front.sv ====
`timescale 1ns/1ns
// Top level of the RV32I instruction front end
// Fetch feeds the decoder, whose record enters the output stage register.
// Sets the reset PC and the stage register mode for the submodules.

module frv_front #(
    parameter logic [31:0] PC_RESET_VALUE = 32'h8000_0000,
    parameter bit          PIPE_BUFFERED  = 1'b1
) (
    input  logic                    g_clk,        // Core clock
    input  logic                    i_rst_n,      // Async reset, active low
    input  logic                    i_cf_req,     // Redirect request
    input  logic [31:0]             i_cf_target,  // Redirect address
    output logic                    o_cf_ack,     // Redirect taken
    input  logic                    i_flush,      // Flush front end
    output logic                    o_imem_cen,   // Instruction memory port
    output logic [31:0]             o_imem_addr,
    input  logic                    i_imem_stall,
    input  logic [31:0]             i_imem_rdata,
    input  logic                    i_imem_error,
    output logic                    o_s2_valid,   // Decoded record out
    output frv_front_pkg::frv_dec_t o_s2_dec,
    input  logic                    i_s2_busy     // Next stage stalled
);

    import frv_front_pkg::*;

    logic       fe_valid;   // Fetched word valid
    frv_fetch_t fe_item;
    frv_dec_t   dec;        // Decoder output
    logic       s1_busy;    // Stage register stalls fetch

    // --------------------------------------------------
    // Fetch, decode, stage register
    frv_fetch #(
        .PC_RESET_VALUE (PC_RESET_VALUE)
    ) i_fetch (
        .g_clk        (g_clk),
        .i_rst_n      (i_rst_n),
        .i_cf_req     (i_cf_req),
        .i_cf_target  (i_cf_target),
        .o_cf_ack     (o_cf_ack),
        .i_flush      (i_flush),
        .i_stall      (s1_busy),
        .o_imem_cen   (o_imem_cen),
        .o_imem_addr  (o_imem_addr),
        .i_imem_stall (i_imem_stall),
        .i_imem_rdata (i_imem_rdata),
        .i_imem_error (i_imem_error),
        .o_valid      (fe_valid),
        .o_fetch      (fe_item)
    );

    frv_decode i_decode (
        .i_fetch (fe_item),
        .o_dec   (dec)
    );

    frv_pipe_reg #(
        .PIPE_BUFFERED (PIPE_BUFFERED)
    ) i_pipe_reg (
        .g_clk   (g_clk),
        .i_rst_n (i_rst_n),
        .i_flush (i_flush),
        .i_valid (fe_valid),
        .i_data  (dec),
        .o_busy  (s1_busy),
        .o_valid (o_s2_valid),
        .o_data  (o_s2_dec),
        .i_busy  (i_s2_busy)
    );

endmodule

// ==== hw/frv_front_pkg.sv ====
// Shared types for the RV32I instruction front end
// Fetch, decode and the stage register import this package

package frv_front_pkg;

    // --------------------------------------------------
    // One micro-op per supported RV32I instruction
    typedef enum logic [4:0] {
        UOP_ADD,            // ALU ops
        UOP_SUB,
        UOP_AND,
        UOP_OR,
        UOP_XOR,
        UOP_SLL,
        UOP_SRL,
        UOP_SRA,
        UOP_SLT,
        UOP_SLTU,
        UOP_LUI,
        UOP_AUIPC,
        UOP_JAL,            // Jumps and branches
        UOP_JALR,
        UOP_BEQ,
        UOP_BNE,
        UOP_BLT,
        UOP_BGE,
        UOP_BLTU,
        UOP_BGEU,
        UOP_LB,             // Loads
        UOP_LH,
        UOP_LW,
        UOP_LBU,
        UOP_LHU,
        UOP_SB,             // Stores
        UOP_SH,
        UOP_SW,
        UOP_NONE            // Trapped instruction
    } frv_uop_e;

    // Functional unit that takes the micro-op
    typedef enum logic [1:0] {
        FU_ALU,
        FU_MEM,
        FU_JMP
    } frv_fu_e;

    // --------------------------------------------------
    // Records passed between stages
    typedef struct packed {
        logic [31:0] pc;    // Address the word came from
        logic [31:0] instr; // Raw instruction word
        logic        error; // Memory fault on this fetch
    } frv_fetch_t;

    typedef struct packed {
        logic [4:0]  rd;    // Zero when not written
        logic [4:0]  rs1;
        logic [4:0]  rs2;   // Zero when not read
        logic [31:0] imm;   // Sign-extended immediate
        logic [31:0] pc;
        frv_uop_e    uop;
        frv_fu_e     fu;
        logic        trap;  // Fetch fault or bad encoding
        logic [31:0] instr;
    } frv_dec_t;

endpackage

// ==== hw/frv_pipe_reg.sv ====
`timescale 1ns/1ns
// Stage register between decode and the rest of the core
// Valid/busy handshake. With PIPE_BUFFERED set, busy is registered and
// a skid entry catches the item taken during the turn-around.

module frv_pipe_reg #(
    parameter bit PIPE_BUFFERED = 1'b1
) (
    input  logic                    g_clk,   // Core clock
    input  logic                    i_rst_n, // Async reset, active low
    input  logic                    i_flush, // Clear all entries
    input  logic                    i_valid, // Item from decode
    input  frv_front_pkg::frv_dec_t i_data,
    output logic                    o_busy,  // Stalls fetch
    output logic                    o_valid, // Item for next stage
    output frv_front_pkg::frv_dec_t o_data,
    input  logic                    i_busy   // Next stage stalled
);

    import frv_front_pkg::*;

    logic     valid_q;
    frv_dec_t data_q;
    logic     out_ready;  // Main entry free or draining

    assign out_ready = ~valid_q | ~i_busy;
    assign o_valid   = valid_q;
    assign o_data    = data_q;

    generate
        if (PIPE_BUFFERED) begin : g_skid
            logic     skid_valid_q;
            frv_dec_t skid_q;

            assign o_busy = skid_valid_q;   // Registered busy

            always_ff @(posedge g_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                    valid_q      <= 1'b0;
                    skid_valid_q <= 1'b0;
                end else if (i_flush) begin
                    valid_q      <= 1'b0;
                    skid_valid_q <= 1'b0;
                end else if (skid_valid_q) begin
                    if (out_ready) begin    // Skid moves to main
                        valid_q      <= 1'b1;
                        skid_valid_q <= 1'b0;
                    end
                end else if (out_ready) begin
                    valid_q <= i_valid;
                end else if (i_valid) begin
                    skid_valid_q <= 1'b1;   // Caught in the turn-around
                end
            end

            always_ff @(posedge g_clk) begin
                if (skid_valid_q) begin
                    if (out_ready) begin
                        data_q <= skid_q;
                    end
                end else if (out_ready) begin
                    if (i_valid) begin
                        data_q <= i_data;
                    end
                end else if (i_valid) begin
                    skid_q <= i_data;
                end
            end
        end else begin : g_direct
            assign o_busy = valid_q & i_busy;   // Busy passes straight back

            always_ff @(posedge g_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                    valid_q <= 1'b0;
                end else if (i_flush) begin
                    valid_q <= 1'b0;
                end else if (out_ready) begin
                    valid_q <= i_valid;
                end
            end

            always_ff @(posedge g_clk) begin
                if (out_ready && i_valid) begin
                    data_q <= i_data;
                end
            end
        end
    endgenerate

    // Output must not move while the next stage stalls
    a_data_held: assert property (
        @(posedge g_clk) disable iff (!i_rst_n)
        (o_valid && i_busy) |=> $stable(o_data)
    ) else $error("stage data changed while next stage busy");

endmodule

// ==== test/frv_front_testdata.txt ====
# M addr word | F fault addr | R records seen before redirect, target
# E pc instr uop fu rd rs1 rs2 imm trap (all hex, uop/fu as enum values)
M 80000000 123452b7
M 80000004 fff28313
M 80000008 405303b3
M 8000000c 4033d413
M 80000010 00812483
M 80000014 fe912e23
M 80000018 fe628ce3
M 8000001c 010000ef
M 80000020 00000073
M 80000024 00500513
M 80000040 00001197
M 80000044 fff1c603
M 80000048 0ff0000f
M 8000004c 00527663
M 80000050 01f71713
F 80000024
E 80000000 123452b7 0a 0 05 00 00 12345000 0
E 80000004 fff28313 00 0 06 05 00 ffffffff 0
E 80000008 405303b3 01 0 07 06 05 00000000 0
E 8000000c 4033d413 07 0 08 07 00 00000003 0
E 80000010 00812483 16 1 09 02 00 00000008 0
E 80000014 fe912e23 1b 1 00 02 09 fffffffc 0
R 06 80000040
E 80000040 00001197 0b 0 03 00 00 00001000 0
E 80000044 fff1c603 17 1 0c 03 00 ffffffff 0
E 80000048 0ff0000f 1c 0 00 00 00 00000000 1
E 8000004c 00527663 13 2 00 04 05 0000000c 0
E 80000050 01f71713 05 0 0e 0e 00 0000001f 0
R 0b 80000018
E 80000018 fe628ce3 0e 2 00 05 06 fffffff8 0
E 8000001c 010000ef 0c 2 01 00 00 00000010 0
E 80000020 00000073 1c 0 00 00 00 00000000 1
E 80000024 00500513 1c 0 00 00 00 00000000 1

// ==== test/tb_frv_front.sv ====
`timescale 1ns/1ns
// Testbench for the RV32I instruction front end
// Loads program, fault addresses, redirect points and expected records
// from test/frv_front_testdata.txt, then runs them under random memory
// stalls and random back-pressure on the output stage.

module tb_frv_front;

    import frv_front_pkg::*;

    localparam logic [31:0] PC_RESET   = 32'h8000_0000;
    localparam logic [31:0] MEM_BASE   = 32'h8000_0000;
    localparam int          MEM_WORDS  = 32;
    localparam int          MAX_ITEMS  = 32;
    localparam int          WAIT_LIMIT = 200;  // Cycles allowed per record
    localparam int          SAMPLE_AT  = 40;   // ns after falling edge

    logic        g_clk;
    logic        i_rst_n;
    logic        i_cf_req;
    logic [31:0] i_cf_target;
    logic        o_cf_ack;
    logic        i_flush;
    logic        o_imem_cen;
    logic [31:0] o_imem_addr;
    logic        i_imem_stall;
    logic [31:0] i_imem_rdata;
    logic        i_imem_error;
    logic        o_s2_valid;
    frv_dec_t    o_s2_dec;
    logic        i_s2_busy;

    logic [31:0] mem [0:MEM_WORDS-1];       // Program image
    logic        fault_map [0:MEM_WORDS-1]; // Words that return an error
    frv_dec_t    exp_rec [0:MAX_ITEMS-1];
    int          redir_count [0:MAX_ITEMS-1];
    logic [31:0] redir_target [0:MAX_ITEMS-1];
    int          n_exp;
    int          n_redir;
    logic [31:0] lfsr;
    logic        acc_pending;  // Request accepted at the last rising edge
    logic [31:0] acc_addr;
    logic        held_valid;   // Stalled request seen last cycle
    logic [31:0] held_addr;

    frv_front #(
        .PC_RESET_VALUE (PC_RESET),
        .PIPE_BUFFERED  (1'b1)
    ) i_dut (
        .g_clk        (g_clk),
        .i_rst_n      (i_rst_n),
        .i_cf_req     (i_cf_req),
        .i_cf_target  (i_cf_target),
        .o_cf_ack     (o_cf_ack),
        .i_flush      (i_flush),
        .o_imem_cen   (o_imem_cen),
        .o_imem_addr  (o_imem_addr),
        .i_imem_stall (i_imem_stall),
        .i_imem_rdata (i_imem_rdata),
        .i_imem_error (i_imem_error),
        .o_s2_valid   (o_s2_valid),
        .o_s2_dec     (o_s2_dec),
        .i_s2_busy    (i_s2_busy)
    );

    initial begin
        g_clk = 1'b0;
        forever #50 g_clk = ~g_clk;  // 100 ns period
    end

    // --------------------------------------------------
    // Helpers
    task automatic end_with_failure();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, want);
            end_with_failure();
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Galois taps
    endfunction

    task automatic random_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b    = lfsr[0];
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ 32'h5c3a_9e17;  // Unloaded words
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - MEM_BASE;
        return (off < MEM_WORDS * 4) ? mem[off >> 2] : fill_word(addr);
    endfunction

    function automatic logic is_fault(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - MEM_BASE;
        return (off < MEM_WORDS * 4) ? fault_map[off >> 2] : 1'b0;
    endfunction

    // --------------------------------------------------
    // Test data has one letter per line kind and hex numbers
    task automatic load_testdata();
        int          fd;
        int          n;
        int          c;
        logic [7:0]  kind;
        logic [31:0] a [0:8];
        frv_dec_t    e;

        n_exp   = 0;
        n_redir = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]       = fill_word(MEM_BASE + 4 * i);
            fault_map[i] = 1'b0;
        end
        fd = $fopen("test/frv_front_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open test/frv_front_testdata.txt");
            end_with_failure();
        end else begin
            n = $fscanf(fd, " %c", kind);
            while (n == 1) begin
                case (kind)
                    "#": begin                    // Comment to end of line
                        c = $fgetc(fd);
                        while (c != "\n" && c != -1) begin
                            c = $fgetc(fd);
                        end
                    end
                    "M": begin
                        n = $fscanf(fd, "%h %h", a[0], a[1]);
                        mem[(a[0] - MEM_BASE) >> 2] = a[1];
                    end
                    "F": begin
                        n = $fscanf(fd, "%h", a[0]);
                        fault_map[(a[0] - MEM_BASE) >> 2] = 1'b1;
                    end
                    "R": begin
                        n = $fscanf(fd, "%h %h", a[0], a[1]);
                        redir_count[n_redir]  = a[0];
                        redir_target[n_redir] = a[1];
                        n_redir++;
                    end
                    "E": begin
                        n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", a[0], a[1], a[2],
                                    a[3], a[4], a[5], a[6], a[7], a[8]);
                        e.pc    = a[0];
                        e.instr = a[1];
                        e.uop   = frv_uop_e'(a[2][4:0]);
                        e.fu    = frv_fu_e'(a[3][1:0]);
                        e.rd    = a[4][4:0];
                        e.rs1   = a[5][4:0];
                        e.rs2   = a[6][4:0];
                        e.imm   = a[7];
                        e.trap  = a[8][0];
                        exp_rec[n_exp] = e;
                        n_exp++;
                    end
                    default: begin
                        $display("Unknown line kind '%c' in test data", kind);
                        end_with_failure();
                    end
                endcase
                n = $fscanf(fd, " %c", kind);
            end
            $fclose(fd);
        end
    endtask

    // --------------------------------------------------
    // Drive one cycle at the falling edge and sample before the rising edge
    task automatic step_cycle(input logic redirect, input logic [31:0] target,
                              output logic taken, output frv_dec_t rec);
        logic b0;
        logic b1;

        @(negedge g_clk);
        if (acc_pending) begin                      // Memory answers last request
            i_imem_rdata = fetch_word(acc_addr);
            i_imem_error = is_fault(acc_addr);
            acc_pending  = 1'b0;
        end
        random_bit(b0);
        random_bit(b1);
        i_imem_stall = b0 & b1;
        random_bit(b0);
        random_bit(b1);
        i_s2_busy   = redirect | (b0 & b1);         // No transfer in flush cycle
        i_cf_req    = redirect;
        i_flush     = redirect;
        i_cf_target = target;
        #SAMPLE_AT;
        if (held_valid) begin
            check_value("o_imem_addr", o_imem_addr, held_addr);
        end
        held_valid = o_imem_cen & i_imem_stall;
        held_addr  = o_imem_addr;
        check_value("o_cf_ack", {31'd0, o_cf_ack}, {31'd0, redirect});
        if (o_imem_cen && !i_imem_stall) begin
            acc_pending = 1'b1;
            acc_addr    = o_imem_addr;
        end
        taken = o_s2_valid & ~i_s2_busy;
        rec   = o_s2_dec;
    endtask

    task automatic compare_record(input int idx, input frv_dec_t got);
        frv_dec_t want;

        want = exp_rec[idx];
        check_value($sformatf("o_s2_dec[%0d].pc", idx), got.pc, want.pc);
        check_value($sformatf("o_s2_dec[%0d].instr", idx), got.instr, want.instr);
        check_value($sformatf("o_s2_dec[%0d].uop", idx), {27'd0, got.uop}, {27'd0, want.uop});
        check_value($sformatf("o_s2_dec[%0d].fu", idx), {30'd0, got.fu}, {30'd0, want.fu});
        check_value($sformatf("o_s2_dec[%0d].rd", idx), {27'd0, got.rd}, {27'd0, want.rd});
        check_value($sformatf("o_s2_dec[%0d].rs1", idx), {27'd0, got.rs1}, {27'd0, want.rs1});
        check_value($sformatf("o_s2_dec[%0d].rs2", idx), {27'd0, got.rs2}, {27'd0, want.rs2});
        check_value($sformatf("o_s2_dec[%0d].imm", idx), got.imm, want.imm);
        check_value($sformatf("o_s2_dec[%0d].trap", idx), {31'd0, got.trap}, {31'd0, want.trap});
    endtask

    // --------------------------------------------------
    // Main sequence
    initial begin : main_seq
        frv_dec_t    rec;
        logic        taken;
        int          ridx;
        int          waited;
        logic        want_target;  // Next record must start at the target
        logic [31:0] target;

        i_rst_n      = 1'b0;
        i_cf_req     = 1'b0;
        i_cf_target  = 32'd0;
        i_flush      = 1'b0;
        i_imem_stall = 1'b0;
        i_imem_rdata = 32'd0;
        i_imem_error = 1'b0;
        i_s2_busy    = 1'b0;
        lfsr         = 32'he50d_be42;
        acc_pending  = 1'b0;
        acc_addr     = 32'd0;
        held_valid   = 1'b0;
        held_addr    = 32'd0;
        ridx         = 0;
        want_target  = 1'b0;
        target       = 32'd0;
        load_testdata();

        repeat (5) @(negedge g_clk);
        check_value("o_imem_cen", {31'd0, o_imem_cen}, 32'd0);  // Quiet in reset
        check_value("o_cf_ack", {31'd0, o_cf_ack}, 32'd0);
        check_value("o_s2_valid", {31'd0, o_s2_valid}, 32'd0);
        i_rst_n = 1'b1;

        for (int idx = 0; idx < n_exp; idx++) begin
            if (ridx < n_redir && idx == redir_count[ridx]) begin
                target = redir_target[ridx];
                step_cycle(1'b1, target, taken, rec);
                want_target = 1'b1;
                ridx++;
            end
            taken  = 1'b0;
            waited = 0;
            while (!taken) begin
                if (waited >= WAIT_LIMIT) begin
                    $display("Timeout waiting for decoded record %0d", idx);
                    end_with_failure();
                end else begin
                    step_cycle(1'b0, 32'd0, taken, rec);
                    waited++;
                end
            end
            if (idx == 0) begin
                check_value("o_s2_dec.pc after reset", rec.pc, PC_RESET);
            end
            if (want_target) begin
                check_value("o_s2_dec.pc after redirect", rec.pc, target);
                want_target = 1'b0;
            end
            compare_record(idx, rec);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule
